/* hw/aes_pkg.sv */
`default_nettype none

package aes_pkg;

  typedef logic [7:0]  aes_byte_t;
  typedef logic [31:0] aes_word_t;

  // byte 0 and column 0 sit at the top of the block
  typedef union packed {
    aes_byte_t [0:15] bytes;
    aes_word_t [0:3]  cols;
  } aes_block_u;

  typedef enum logic [2:0] {
    phase_idle,
    phase_add_key,
    phase_sub_bytes,
    phase_shift_rows,   // key expansion runs here too
    phase_mix_columns
  } aes_phase_e;

  typedef struct packed {
    aes_phase_e phase;
    logic [3:0] round;
    logic       first_round;
  } aes_ctrl_t;

  typedef struct packed {
    aes_block_u block;
    aes_word_t  key_word;   // SubWord(RotWord(w3))
    logic       done;
  } aes_sub_t;

  localparam int        num_rounds  = 10;
  localparam aes_byte_t gf_poly     = 8'h1b;
  localparam int        state_bytes = 16;
  localparam int        sbox_reads  = 20;   // state bytes then rotated key word

  function automatic aes_byte_t rcon(input logic [3:0] round);
    case (round)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

`default_nettype wire

/* hw/aes_mix_column.sv */
`default_nettype none

module aes_mix_column (
  input  wire aes_pkg::aes_word_t col_i,
  output aes_pkg::aes_word_t      col_o
);

  aes_pkg::aes_byte_t [0:3] a;
  aes_pkg::aes_byte_t [0:3] x;
  aes_pkg::aes_byte_t [0:3] m;

  // multiply by 2 in GF(2^8)
  function automatic aes_pkg::aes_byte_t xtime(input aes_pkg::aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? aes_pkg::gf_poly : 8'h00);
  endfunction

  assign a = col_i;

  // row i of the circulant 2 3 1 1 matrix
  for (genvar i = 0; i < 4; i++)
  begin : g_row
    assign x[i] = xtime(a[i]);
    assign m[i] = x[i] ^ x[(i+1)%4] ^ a[(i+1)%4] ^ a[(i+2)%4] ^ a[(i+3)%4];
  end

  assign col_o = m;

endmodule

`default_nettype wire

/* hw/aes_ctrl.sv */
`default_nettype none

module aes_ctrl (
  input  wire                clk,
  input  wire                rst,
  input  wire                sub_done_i,
  output logic               done_o,
  output aes_pkg::aes_ctrl_t ctrl_o
);

  localparam logic [3:0] last_round = 4'(aes_pkg::num_rounds);

  aes_pkg::aes_phase_e phase_q;
  aes_pkg::aes_phase_e phase_d;
  logic [3:0]          round_q;

  always_comb
  begin
    phase_d = phase_q;
    case (phase_q)
      aes_pkg::phase_idle:        phase_d = aes_pkg::phase_add_key;
      aes_pkg::phase_add_key:     phase_d = aes_pkg::phase_sub_bytes;
      aes_pkg::phase_sub_bytes:
      begin
        if (sub_done_i)
          phase_d = aes_pkg::phase_shift_rows;
      end
      aes_pkg::phase_shift_rows:
      begin
        // last round goes straight to the final key add
        if (round_q < last_round)
          phase_d = aes_pkg::phase_mix_columns;
        else
          phase_d = aes_pkg::phase_add_key;
      end
      aes_pkg::phase_mix_columns: phase_d = aes_pkg::phase_add_key;
      default:                    phase_d = aes_pkg::phase_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase_q <= aes_pkg::phase_idle;
      round_q <= 4'd0;
    end
    else if (done_o)
    begin
      phase_q <= aes_pkg::phase_idle;   // restart on next block
      round_q <= 4'd0;
    end
    else
    begin
      phase_q <= phase_d;
      if (phase_q == aes_pkg::phase_add_key)
        round_q <= round_q + 4'd1;
    end
  end

  // the final key add ends the block, round is 11 while done is high
  always_ff @(posedge clk)
  begin
    if (rst)
      done_o <= 1'b0;
    else
      done_o <= (phase_q == aes_pkg::phase_add_key) && (round_q == last_round);
  end

  assign ctrl_o.phase       = phase_q;
  assign ctrl_o.round       = round_q;
  assign ctrl_o.first_round = (round_q == 4'd0);

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_o |=> !done_o);

  // sub_bytes only ends on the sequencer's done or a finished block
  a_sub_hold: assert property (@(posedge clk) disable iff (rst)
    (phase_q == aes_pkg::phase_sub_bytes && !sub_done_i && !done_o)
      |=> phase_q == aes_pkg::phase_sub_bytes);

endmodule

`default_nettype wire

/* hw/aes_sbox_seq.sv */
`default_nettype none

module aes_sbox_seq #(
  parameter int rom_latency = 1
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire aes_pkg::aes_ctrl_t  ctrl_i,
  input  wire aes_pkg::aes_block_u state_i,
  input  wire aes_pkg::aes_word_t  key_word_i,
  input  wire aes_pkg::aes_byte_t  rom_data_i,
  output aes_pkg::aes_byte_t  rom_addr_o,
  output aes_pkg::aes_sub_t   sub_o
);

  localparam int last_count = aes_pkg::sbox_reads + rom_latency;
  localparam int cnt_w      = $clog2(last_count + 1);
  localparam int idx_w      = $clog2(aes_pkg::sbox_reads);

  logic [cnt_w-1:0]        cnt_q;
  logic                    active;
  logic                    issue;
  logic                    seq_done;
  logic [idx_w-1:0]        issue_idx;
  aes_pkg::aes_byte_t [0:3] key_bytes;
  aes_pkg::aes_byte_t      issue_byte;
  logic [idx_w-1:0]        idx_pipe [0:rom_latency];
  logic [rom_latency:0]    vld_pipe;
  logic [idx_w-1:0]        cap_idx;
  aes_pkg::aes_block_u     res_block;
  aes_pkg::aes_byte_t [0:3] res_key;

  assign active    = (ctrl_i.phase == aes_pkg::phase_sub_bytes);
  assign issue     = active && (cnt_q < cnt_w'(aes_pkg::sbox_reads));
  assign seq_done  = active && (cnt_q == cnt_w'(last_count));
  assign issue_idx = idx_w'(cnt_q);
  assign key_bytes = key_word_i;
  assign cap_idx   = idx_pipe[rom_latency];

  // state bytes first, then the rotated key word
  assign issue_byte = (issue_idx < idx_w'(aes_pkg::state_bytes))
                    ? state_i.bytes[issue_idx[3:0]] : key_bytes[issue_idx[1:0]];

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt_q <= '0;
    else if (!active || seq_done)
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rom_addr_o <= '0;
      vld_pipe   <= '0;
    end
    else
    begin
      if (issue)
        rom_addr_o <= issue_byte;
      vld_pipe[0] <= issue;
      for (int i = 1; i <= rom_latency; i++)
        vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  // index follows its address through the ROM
  always_ff @(posedge clk)
  begin
    idx_pipe[0] <= issue_idx;
    for (int i = 1; i <= rom_latency; i++)
      idx_pipe[i] <= idx_pipe[i-1];
    if (vld_pipe[rom_latency])
    begin
      if (cap_idx < idx_w'(aes_pkg::state_bytes))
        res_block.bytes[cap_idx[3:0]] <= rom_data_i;
      else
        res_key[cap_idx[1:0]] <= rom_data_i;
    end
  end

  assign sub_o.block    = res_block;
  assign sub_o.key_word = res_key;
  assign sub_o.done     = seq_done;

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    cnt_q <= cnt_w'(last_count));

endmodule

`default_nettype wire

/* hw/aes_key_sched.sv */
`default_nettype none

module aes_key_sched (
  input  wire                      clk,
  input  wire                      rst,
  input  wire aes_pkg::aes_ctrl_t  ctrl_i,
  input  wire aes_pkg::aes_block_u key_i,
  input  wire aes_pkg::aes_word_t  sub_word_i,
  output aes_pkg::aes_block_u      round_key_o,
  output aes_pkg::aes_word_t       rot_word_o
);

  aes_pkg::aes_block_u key_q;
  aes_pkg::aes_word_t  last_word_q;   // w3 before RotWord
  aes_pkg::aes_block_u next_key;
  aes_pkg::aes_word_t  rcon_word;

  assign rcon_word = {aes_pkg::rcon(ctrl_i.round), 24'h000000};

  // standard chain, each word folds in its new neighbor
  always_comb
  begin
    next_key.cols[0] = key_q.cols[0] ^ sub_word_i ^ rcon_word;
    next_key.cols[1] = key_q.cols[1] ^ next_key.cols[0];
    next_key.cols[2] = key_q.cols[2] ^ next_key.cols[1];
    next_key.cols[3] = last_word_q ^ next_key.cols[2];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      key_q       <= '0;
      last_word_q <= '0;
    end
    else
    begin
      case (ctrl_i.phase)
        aes_pkg::phase_idle:
        begin
          key_q <= key_i;   // cipher key for round 0
        end
        aes_pkg::phase_add_key:
        begin
          last_word_q   <= key_q.cols[3];
          key_q.cols[3] <= {key_q.cols[3][23:0], key_q.cols[3][31:24]};
        end
        aes_pkg::phase_shift_rows:
        begin
          key_q <= next_key;
        end
        default:
        begin
          key_q <= key_q;
        end
      endcase
    end
  end

  assign round_key_o = key_q;
  assign rot_word_o  = key_q.cols[3];   // rotated during sub_bytes

endmodule

`default_nettype wire

/* hw/aes_state_path.sv */
`default_nettype none

module aes_state_path (
  input  wire                      clk,
  input  wire                      rst,
  input  wire aes_pkg::aes_ctrl_t  ctrl_i,
  input  wire                      done_i,
  input  wire aes_pkg::aes_block_u plaintext_i,
  input  wire aes_pkg::aes_block_u key_i,
  input  wire aes_pkg::aes_block_u round_key_i,
  input  wire aes_pkg::aes_sub_t   sub_i,
  input  wire aes_pkg::aes_block_u mixed_i,
  output aes_pkg::aes_block_u      state_o
);

  aes_pkg::aes_block_u state_q;
  aes_pkg::aes_block_u shifted;
  aes_pkg::aes_block_u state_d;

  // row r rotates left by r columns
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
        shifted.bytes[4*c + r] = state_q.bytes[4*((c + r) % 4) + r];
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (ctrl_i.phase)
      aes_pkg::phase_add_key:
      begin
        if (ctrl_i.first_round)
          state_d = plaintext_i ^ key_i;
        else
          state_d = state_q ^ round_key_i;
      end
      aes_pkg::phase_sub_bytes:
      begin
        if (sub_i.done)
          state_d = sub_i.block;
      end
      aes_pkg::phase_shift_rows:  state_d = shifted;
      aes_pkg::phase_mix_columns: state_d.cols = mixed_i.cols;
      default:                    state_d = state_q;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= '0;
    else if (done_i)
      state_q <= '0;   // ciphertext already out
    else
      state_q <= state_d;
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

/* hw/aes_top.sv */
`default_nettype none

module aes_top #(
  parameter int rom_latency = 1
) (
  input  wire          clk,
  input  wire          rst,
  input  wire  [127:0] plaintext_i,
  input  wire  [127:0] key_i,
  input  wire  [7:0]   rom_data_i,
  output logic [7:0]   rom_addr_o,
  output logic [127:0] ciphertext_o,
  output logic         done_o
);

  aes_pkg::aes_ctrl_t       ctrl;
  aes_pkg::aes_sub_t        sub;
  aes_pkg::aes_block_u      state;
  aes_pkg::aes_block_u      round_key;
  aes_pkg::aes_word_t       rot_word;
  aes_pkg::aes_word_t [0:3] mixed_cols;
  logic                     done;

  aes_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .sub_done_i (sub.done),
    .done_o     (done),
    .ctrl_o     (ctrl)
  );

  aes_sbox_seq #(.rom_latency(rom_latency)) u_sbox_seq (
    .clk        (clk),
    .rst        (rst),
    .ctrl_i     (ctrl),
    .state_i    (state),
    .key_word_i (rot_word),
    .rom_data_i (rom_data_i),
    .rom_addr_o (rom_addr_o),
    .sub_o      (sub)
  );

  aes_key_sched u_key_sched (
    .clk         (clk),
    .rst         (rst),
    .ctrl_i      (ctrl),
    .key_i       (key_i),
    .sub_word_i  (sub.key_word),
    .round_key_o (round_key),
    .rot_word_o  (rot_word)
  );

  aes_state_path u_state_path (
    .clk         (clk),
    .rst         (rst),
    .ctrl_i      (ctrl),
    .done_i      (done),
    .plaintext_i (plaintext_i),
    .key_i       (key_i),
    .round_key_i (round_key),
    .sub_i       (sub),
    .mixed_i     (mixed_cols),
    .state_o     (state)
  );

  for (genvar c = 0; c < 4; c++)
  begin : g_mix
    aes_mix_column u_mix (
      .col_i (state.cols[c]),
      .col_o (mixed_cols[c])
    );
  end

  assign ciphertext_o = state;
  assign done_o       = done;

endmodule

`default_nettype wire

/* tb/aes_tb_vectors.svh */
`ifndef aes_tb_vectors_svh
`define aes_tb_vectors_svh

localparam int num_vectors = 4;

// S-box, entry 0 in the top byte of the first row
localparam logic [0:255][7:0] sbox_table = {
  128'h637c777bf26b6fc53001672bfed7ab76,
  128'hca82c97dfa5947f0add4a2af9ca472c0,
  128'hb7fd9326363ff7cc34a5e5f171d83115,
  128'h04c723c31896059a071280e2eb27b275,
  128'h09832c1a1b6e5aa0523bd6b329e32f84,
  128'h53d100ed20fcb15b6acbbe394a4c58cf,
  128'hd0efaafb434d338545f9027f503c9fa8,
  128'h51a3408f929d38f5bcb6da2110fff3d2,
  128'hcd0c13ec5f974417c4a77e3d645d1973,
  128'h60814fdc222a908846eeb814de5e0bdb,
  128'he0323a0a4906245cc2d3ac629195e479,
  128'he7c8376d8dd54ea96c56f4ea657aae08,
  128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
  128'h703eb5664803f60e613557b986c11d9e,
  128'he1f8981169d98e949b1e87e9ce5528df,
  128'h8ca1890dbfe6426841992d0fb054bb16
};

typedef struct packed {
  logic [127:0] pt;
  logic [127:0] key;
  logic [127:0] ct;   // zero where no published answer exists
} vector_t;

// columns: plaintext, key, expected ciphertext
localparam vector_t [0:num_vectors-1] vector_table = {
  {128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c,
   128'h3925841d02dc09fbdc118597196a0b32},
  {128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f,
   128'h69c4e0d86a7b0430d8cdb78070b4c55a},
  {128'h00000000000000000000000000000000, 128'h00000000000000000000000000000000,
   128'h66e94bd4ef8a2c3b884cfa59ca342b2e},
  {128'hffffffffffffffffffffffffffffffff, 128'hffffffffffffffffffffffffffffffff,
   128'h00000000000000000000000000000000}
};

function automatic string vector_name(input int idx);
  case (idx)
    0:       return "fips197_b";
    1:       return "fips197_c1";
    2:       return "all_zero";
    default: return "all_ones";
  endcase
endfunction

`endif

/* tb/aes_tb.sv */
`default_nettype none

module aes_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "aes_tb_vectors.svh"

  localparam int reset_cycles   = 8;
  localparam int block_cycles   = 300;
  // table blocks, the aborted block and a spare, plus two resets
  localparam int timeout_cycles = (num_vectors + 2) * block_cycles + 2 * reset_cycles;

  logic         clk      = 1'b0;
  logic         rst;
  logic [127:0] plaintext;
  logic [127:0] key;
  logic [7:0]   rom_data = 8'h00;
  logic [7:0]   rom_addr;
  logic [127:0] ciphertext;
  logic         done;

  vector_t    vecs [0:num_vectors-1];
  logic [7:0] addr_hist [$];
  int         errors      = 0;
  int         checks      = 0;
  int         cycle_count = 0;

  aes_top #(.rom_latency(1)) i_dut (
    .clk          (clk),
    .rst          (rst),
    .plaintext_i  (plaintext),
    .key_i        (key),
    .rom_data_i   (rom_data),
    .rom_addr_o   (rom_addr),
    .ciphertext_o (ciphertext),
    .done_o       (done)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    rom_data <= sbox_table[rom_addr];   // synchronous ROM, one cycle read

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout, DUT did not finish within %0d cycles", timeout_cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [7:0] mul2(input logic [7:0] b);
    logic [7:0] r;
    r = b << 1;
    if (b[7])
      r = r ^ 8'h1b;
    return r;
  endfunction

  // byte-wise reference cipher, byte 4*c+r is row r of column c
  function automatic logic [127:0] ref_encrypt(input logic [127:0] pt, input logic [127:0] k_in);
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [7:0]   k [0:15];
    logic [7:0]   rc;
    logic [127:0] res;
    rc = 8'h01;
    for (int i = 0; i < 16; i++)
    begin
      k[i] = k_in[127 - 8*i -: 8];
      s[i] = pt[127 - 8*i -: 8] ^ k[i];
    end
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
      k[0] = k[0] ^ sbox_table[k[13]] ^ rc;
      k[1] = k[1] ^ sbox_table[k[14]];
      k[2] = k[2] ^ sbox_table[k[15]];
      k[3] = k[3] ^ sbox_table[k[12]];
      for (int i = 4; i < 16; i++)
        k[i] = k[i] ^ k[i-4];
      rc = mul2(rc);
      for (int i = 0; i < 16; i++)
        t[i] = sbox_table[s[(i + 4*(i%4)) % 16]];   // sub and shift in one go
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          if (rnd < 10)
            s[4*c+r] = mul2(t[4*c+r]) ^ mul2(t[4*c+(r+1)%4]) ^ t[4*c+(r+1)%4]
                     ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
          else
            s[4*c+r] = t[4*c+r];
        end
      end
      for (int i = 0; i < 16; i++)
        s[i] = s[i] ^ k[i];
    end
    for (int i = 0; i < 16; i++)
      res[127 - 8*i -: 8] = s[i];
    return res;
  endfunction

  task automatic prepare_vectors();
    logic [127:0] model_ct;
    for (int i = 0; i < num_vectors; i++)
    begin
      vecs[i]  = vector_table[i];
      model_ct = ref_encrypt(vecs[i].pt, vecs[i].key);
      if (vecs[i].ct == '0)
        vecs[i].ct = model_ct;
      else
        check_value({"model ", vector_name(i)}, vecs[i].ct, model_ct);
    end
  endtask

  task automatic drive_inputs(input int idx);
    plaintext = vecs[idx].pt;
    key       = vecs[idx].key;
  endtask

  task automatic apply_reset(input int next_idx);
    rst = 1'b1;
    drive_inputs(next_idx);
    repeat (reset_cycles)
    begin
      @(negedge clk);
      check_value("done in reset", 128'd0, 128'(done));
      check_value("rom address in reset", 128'd0, 128'(rom_addr));
    end
    rst = 1'b0;
  endtask

  // waits for done, then checks ciphertext and the order of state reads
  task automatic run_block(input int idx, input bit after_reset);
    logic [127:0] xored;
    logic [127:0] seen;
    bit           found;
    bit           match;
    addr_hist.delete();
    @(negedge clk);
    check_value("done low at block start", 128'd0, 128'(done));
    addr_hist.push_back(rom_addr);
    if (after_reset)
      check_value("rom address before first read", 128'd0, 128'(rom_addr));
    while (!done)
    begin
      @(negedge clk);
      addr_hist.push_back(rom_addr);
    end
    check_value(vector_name(idx), vecs[idx].ct, ciphertext);

    xored = vecs[idx].pt ^ vecs[idx].key;
    found = 1'b0;
    seen  = '0;
    if (addr_hist.size() >= 24)
    begin
      for (int s = 0; s < 8; s++)
      begin
        match = 1'b1;
        for (int j = 0; j < 16; j++)
        begin
          if (addr_hist[s + j] !== xored[127 - 8*j -: 8])
            match = 1'b0;
        end
        found = found | match;
      end
      for (int j = 0; j < 16; j++)
        seen[127 - 8*j -: 8] = addr_hist[3 + j];
    end
    checks++;
    assert (found)
    else
    begin
      $display("CHECK FAILED %s rom order expected %h actual %h", vector_name(idx), xored, seen);
      errors++;
    end
  endtask

  initial
  begin
    int abort_cycle;
    rst         = 1'b1;
    plaintext   = '0;
    key         = '0;
    abort_cycle = int'($urandom(32'h7d14));   // seeds the generator
    abort_cycle = 16 + int'($urandom % 200);
    prepare_vectors();
    apply_reset(0);

    for (int i = 0; i < num_vectors; i++)
    begin
      run_block(i, i == 0);
      if (i + 1 < num_vectors)
        drive_inputs(i + 1);   // back to back, no reset
    end

    // start a block and cut it short with reset
    drive_inputs(1);
    repeat (abort_cycle)
    begin
      @(negedge clk);
      check_value("done before abort", 128'd0, 128'(done));
    end
    apply_reset(2);
    run_block(2, 1'b1);
    @(negedge clk);
    check_value("done pulse width", 128'd0, 128'(done));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+tb
hw/aes_pkg.sv
hw/aes_mix_column.sv
hw/aes_ctrl.sv
hw/aes_sbox_seq.sv
hw/aes_key_sched.sv
hw/aes_state_path.sv
hw/aes_top.sv
tb/aes_tb.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= aes_tb
FILELIST   ?= build.f
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG    = test failed
PASS_MSG    = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
